// File: logic/regReadPkg.sv
// Sizes and vector types shared by the register-read stage; imported by every design unit
package regReadPkg;

  // Machine width
  localparam int ISSUE_WIDTH = 4;  // Issue lanes and writeback ports

  // Physical register file
  localparam int PHYS_REGS  = 64;
  localparam int PHYS_TAG_W = 6;
  localparam int ARCH_REGS  = 32;  // Tags below this are ready out of reset
  localparam int DATA_W     = 32;

  // Branch checkpoints
  localparam int CHECKPOINTS = 4;
  localparam int CKPT_ID_W   = 2;

  // Everything the stage carries but never looks at
  localparam int PAYLOAD_W = 16;

  // Physical register name
  typedef logic [PHYS_TAG_W-1:0] physTag_t;

  // One operand value
  typedef logic [DATA_W-1:0] regData_t;

  // Set bit means the instruction depends on that checkpoint
  typedef logic [CHECKPOINTS-1:0] branchMask_t;

  // Checkpoint index
  typedef logic [CKPT_ID_W-1:0] ckptId_t;

  // Opaque instruction fields
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // One ready bit per physical register
  typedef logic [PHYS_REGS-1:0] readyVec_t;

endpackage

// File: logic/rfReadIf.sv
// One lane's two-operand read port into the physical register file with tags out and data back
`timescale 1ns/100ps

interface rfReadIf;
  import regReadPkg::*;

  physTag_t src1Tag;
  physTag_t src2Tag;
  regData_t src1Data;  // Same-cycle answer for src1Tag
  regData_t src2Data;

  // Lane side
  modport reader (
    output src1Tag,
    output src2Tag,
    input  src1Data,
    input  src2Data
  );

  // Register file side
  modport regFile (
    input  src1Tag,
    input  src2Tag,
    output src1Data,
    output src2Data
  );

endinterface

// File: logic/physRegFile.sv
// Flop-based physical register file with eight asynchronous reads and four writes per clock
`timescale 1ns/100ps

module physRegFile (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   wbValid_i,
  input  regReadPkg::physTag_t                 wbTag_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::regData_t                 wbData_i [regReadPkg::ISSUE_WIDTH],
  input  logic                                 recover_i,
  rfReadIf.regFile                             rdPort [regReadPkg::ISSUE_WIDTH]
);
  import regReadPkg::*;

  regData_t regs [PHYS_REGS];
  logic     dupTag;

  // Writes are held off during recovery
  always_ff @(posedge clk) begin
    if (!recover_i) begin
      for (int w = 0; w < ISSUE_WIDTH; w++) begin
        if (wbValid_i[w]) regs[wbTag_i[w]] <= wbData_i[w];
      end
    end
  end

  // Two read ports per lane
  for (genvar p = 0; p < ISSUE_WIDTH; p++) begin : gRead
    assign rdPort[p].src1Data = regs[rdPort[p].src1Tag];
    assign rdPort[p].src2Data = regs[rdPort[p].src2Tag];
  end

  // Any pair of live write ports aimed at one register
  always_comb begin
    dupTag = 1'b0;
    for (int a = 0; a < ISSUE_WIDTH; a++) begin
      for (int b = a + 1; b < ISSUE_WIDTH; b++) begin
        if (wbValid_i[a] && wbValid_i[b] && (wbTag_i[a] == wbTag_i[b])) dupTag = 1'b1;
      end
    end
  end

  // Write order between ports is undefined, so the issue logic must never allow it
  assert property (@(posedge clk) disable iff (reset_i) !dupTag)
    else $error("physRegFile: two writeback ports target the same tag");

endmodule

// File: logic/laneOperandRead.sv
// One issue lane with writeback bypass, operand select, mispredict squash and the output flops
`timescale 1ns/100ps

module laneOperandRead (
  input  logic                                 clk,
  input  logic                                 reset_i,

  // Issued instruction
  input  logic                                 inValid_i,
  input  regReadPkg::branchMask_t              inMask_i,
  input  regReadPkg::physTag_t                 inSrc1_i,
  input  regReadPkg::physTag_t                 inSrc2_i,
  input  regReadPkg::physTag_t                 inDest_i,
  input  regReadPkg::payload_t                 inPayload_i,

  // Writeback bus
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   wbValid_i,
  input  regReadPkg::physTag_t                 wbTag_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::regData_t                 wbData_i [regReadPkg::ISSUE_WIDTH],

  // Branch resolution
  input  logic                                 ctrlVerified_i,
  input  logic                                 ctrlMispredict_i,
  input  regReadPkg::ckptId_t                  ctrlCkptId_i,

  rfReadIf.reader                              rf,

  // Registered result
  output logic                                 outValid_o,
  output regReadPkg::regData_t                 outSrc1Data_o,
  output regReadPkg::regData_t                 outSrc2Data_o,
  output regReadPkg::physTag_t                 outSrc1_o,
  output regReadPkg::physTag_t                 outSrc2_o,
  output regReadPkg::physTag_t                 outDest_o,
  output regReadPkg::payload_t                 outPayload_o,
  output regReadPkg::branchMask_t              outMask_o
);
  import regReadPkg::*;

  logic [ISSUE_WIDTH-1:0] src1Hit;
  logic [ISSUE_WIDTH-1:0] src2Hit;
  regData_t               src1Sel;
  regData_t               src2Sel;
  logic                   squash;

  assign rf.src1Tag = inSrc1_i;
  assign rf.src2Tag = inSrc2_i;

  // A same-cycle writeback beats the array, which only sees it next cycle
  always_comb begin
    src1Sel = rf.src1Data;
    src2Sel = rf.src2Data;
    for (int w = 0; w < ISSUE_WIDTH; w++) begin
      src1Hit[w] = wbValid_i[w] && (wbTag_i[w] == inSrc1_i);
      src2Hit[w] = wbValid_i[w] && (wbTag_i[w] == inSrc2_i);
      if (src1Hit[w]) src1Sel = wbData_i[w];
      if (src2Hit[w]) src2Sel = wbData_i[w];
    end
  end

  // Killed if the mispredicted branch is one this instruction sits behind
  assign squash = ctrlVerified_i && ctrlMispredict_i && inMask_i[ctrlCkptId_i];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      outValid_o <= 1'b0;
    end else begin
      outValid_o <= inValid_i && !squash;
    end
  end

  always_ff @(posedge clk) begin
    outSrc1Data_o <= src1Sel;
    outSrc2Data_o <= src2Sel;
    outSrc1_o     <= inSrc1_i;
    outSrc2_o     <= inSrc2_i;
    outDest_o     <= inDest_i;
    outPayload_o  <= inPayload_i;
    outMask_o     <= inMask_i;
  end

  // Bypass mux is priority coded, so more than one hit would hide a write conflict
  assert property (@(posedge clk) disable iff (reset_i)
    inValid_i |-> ($onehot0(src1Hit) && $onehot0(src2Hit)))
    else $error("laneOperandRead: source matches several writebacks");

endmodule

// File: logic/readyTable.sv
// Physical register ready bits that clear on unmap and set on result-tag broadcast
`timescale 1ns/100ps

module readyTable (
  input  logic                                 clk,
  input  logic                                 reset_i,
  input  logic                                 exception_i,
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   unmapValid_i,
  input  regReadPkg::physTag_t                 unmapTag_i [regReadPkg::ISSUE_WIDTH],
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   rsrValid_i,
  input  regReadPkg::physTag_t                 rsrTag_i [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::readyVec_t                ready_o
);
  import regReadPkg::*;

  readyVec_t readyQ;
  readyVec_t resetVec;
  readyVec_t readyNext;

  // Committed architectural state only
  always_comb begin
    for (int t = 0; t < PHYS_REGS; t++) begin
      resetVec[t] = (t < ARCH_REGS);
    end
  end

  always_comb begin
    readyNext = readyQ;
    for (int u = 0; u < ISSUE_WIDTH; u++) begin
      if (unmapValid_i[u]) readyNext[unmapTag_i[u]] = 1'b0;
    end
    for (int r = 0; r < ISSUE_WIDTH; r++) begin
      if (rsrValid_i[r]) readyNext[rsrTag_i[r]] = 1'b1;  // Set wins over clear
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || exception_i) begin
      readyQ <= resetVec;
    end else begin
      readyQ <= readyNext;
    end
  end

  assign ready_o = readyQ;

  // Issue wakeup depends on the architectural registers being ready out of reset
  assert property (@(posedge clk) reset_i |=> (&ready_o[ARCH_REGS-1:0]))
    else $error("readyTable: architectural registers not ready after reset");

endmodule

// File: logic/regReadStage.sv
// Register-read stage top with four operand lanes around an 8R4W register file and the ready table
`timescale 1ns/100ps

module regReadStage (
  input  logic                                 clk,
  input  logic                                 reset_i,

  // Issued instructions, one entry per lane
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   laneValid_i,
  input  regReadPkg::branchMask_t              laneMask_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::physTag_t                 laneSrc1_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::physTag_t                 laneSrc2_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::physTag_t                 laneDest_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::payload_t                 lanePayload_i [regReadPkg::ISSUE_WIDTH],

  // Writeback bus
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   wbValid_i,
  input  regReadPkg::physTag_t                 wbTag_i [regReadPkg::ISSUE_WIDTH],
  input  regReadPkg::regData_t                 wbData_i [regReadPkg::ISSUE_WIDTH],

  // Pipeline control
  input  logic                                 recover_i,
  input  logic                                 exception_i,
  input  logic                                 ctrlVerified_i,
  input  logic                                 ctrlMispredict_i,
  input  regReadPkg::ckptId_t                  ctrlCkptId_i,

  // Ready table updates
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   unmapValid_i,
  input  regReadPkg::physTag_t                 unmapTag_i [regReadPkg::ISSUE_WIDTH],
  input  logic [regReadPkg::ISSUE_WIDTH-1:0]   rsrValid_i,
  input  regReadPkg::physTag_t                 rsrTag_i [regReadPkg::ISSUE_WIDTH],

  // Instructions with operands one cycle later
  output logic [regReadPkg::ISSUE_WIDTH-1:0]   laneValid_o,
  output regReadPkg::regData_t                 laneSrc1Data_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::regData_t                 laneSrc2Data_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::physTag_t                 laneSrc1_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::physTag_t                 laneSrc2_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::physTag_t                 laneDest_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::payload_t                 lanePayload_o [regReadPkg::ISSUE_WIDTH],
  output regReadPkg::branchMask_t              laneMask_o [regReadPkg::ISSUE_WIDTH],

  output regReadPkg::readyVec_t                phyRegRdy_o
);
  import regReadPkg::*;

  // Two read ports per lane
  rfReadIf rfRead [ISSUE_WIDTH] ();

  physRegFile uRegFile (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbValid_i (wbValid_i),
    .wbTag_i   (wbTag_i),
    .wbData_i  (wbData_i),
    .recover_i (recover_i),
    .rdPort    (rfRead)
  );

  readyTable uReadyTable (
    .clk          (clk),
    .reset_i      (reset_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .rsrValid_i   (rsrValid_i),
    .rsrTag_i     (rsrTag_i),
    .ready_o      (phyRegRdy_o)
  );

  for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : gLane
    laneOperandRead uLane (
      .clk              (clk),
      .reset_i          (reset_i),
      .inValid_i        (laneValid_i[l]),
      .inMask_i         (laneMask_i[l]),
      .inSrc1_i         (laneSrc1_i[l]),
      .inSrc2_i         (laneSrc2_i[l]),
      .inDest_i         (laneDest_i[l]),
      .inPayload_i      (lanePayload_i[l]),
      .wbValid_i        (wbValid_i),
      .wbTag_i          (wbTag_i),
      .wbData_i         (wbData_i),
      .ctrlVerified_i   (ctrlVerified_i),
      .ctrlMispredict_i (ctrlMispredict_i),
      .ctrlCkptId_i     (ctrlCkptId_i),
      .rf               (rfRead[l]),
      .outValid_o       (laneValid_o[l]),
      .outSrc1Data_o    (laneSrc1Data_o[l]),
      .outSrc2Data_o    (laneSrc2Data_o[l]),
      .outSrc1_o        (laneSrc1_o[l]),
      .outSrc2_o        (laneSrc2_o[l]),
      .outDest_o        (laneDest_o[l]),
      .outPayload_o     (lanePayload_o[l]),
      .outMask_o        (laneMask_o[l])
    );
  end

endmodule

// File: sim/regReadModel.svh
// Reference model for the register-read testbench, included into the testbench top module
`ifndef REG_READ_MODEL_SVH
`define REG_READ_MODEL_SVH

regData_t    shadowRegs [PHYS_REGS];  // Contents the register file should hold
readyVec_t   expReady;
laneBits_t   expValid;
laneBits_t   expLive;                 // Lane carried an instruction, so its fields count
regData_t    expSrc1Data [ISSUE_WIDTH];
regData_t    expSrc2Data [ISSUE_WIDTH];
physTag_t    expSrc1 [ISSUE_WIDTH];
physTag_t    expSrc2 [ISSUE_WIDTH];
physTag_t    expDest [ISSUE_WIDTH];
payload_t    expPayload [ISSUE_WIDTH];
branchMask_t expMask [ISSUE_WIDTH];

// Architectural registers ready and renamed ones not
function automatic readyVec_t resetPattern();
  return {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
endfunction

// Same-cycle writeback wins over the stored value
function automatic regData_t operandFor(physTag_t tag);
  regData_t val;
  val = shadowRegs[tag];
  for (int w = 0; w < ISSUE_WIDTH; w++) begin
    if (wbValid_i[w] && (wbTag_i[w] == tag)) val = wbData_i[w];
  end
  return val;
endfunction

function automatic bit laneSurvives(int l);
  bit killed;
  killed = ctrlVerified_i && ctrlMispredict_i && laneMask_i[l][ctrlCkptId_i];
  return laneValid_i[l] && !reset_i && !killed;
endfunction

// Ready bits after the current cycle's updates
function automatic readyVec_t readyAfter(readyVec_t cur);
  readyVec_t nxt;
  if (reset_i || exception_i) return resetPattern();
  nxt = cur;
  for (int u = 0; u < ISSUE_WIDTH; u++) begin
    if (unmapValid_i[u]) nxt[unmapTag_i[u]] = 1'b0;
  end
  for (int r = 0; r < ISSUE_WIDTH; r++) begin
    if (rsrValid_i[r]) nxt[rsrTag_i[r]] = 1'b1;  // Set beats clear
  end
  return nxt;
endfunction

function automatic void captureExpected();
  for (int l = 0; l < ISSUE_WIDTH; l++) begin
    expValid[l]    = laneSurvives(l);
    expLive[l]     = laneValid_i[l] && !reset_i;
    expSrc1Data[l] = operandFor(laneSrc1_i[l]);
    expSrc2Data[l] = operandFor(laneSrc2_i[l]);
    expSrc1[l]     = laneSrc1_i[l];
    expSrc2[l]     = laneSrc2_i[l];
    expDest[l]     = laneDest_i[l];
    expPayload[l]  = lanePayload_i[l];
    expMask[l]     = laneMask_i[l];
  end
endfunction

// Recovery blocks the array write only
function automatic void commitWrites();
  if (recover_i) return;
  for (int w = 0; w < ISSUE_WIDTH; w++) begin
    if (wbValid_i[w]) shadowRegs[wbTag_i[w]] = wbData_i[w];
  end
endfunction

`endif

// File: sim/regReadTb.sv
// Self-checking testbench top for the register-read stage that the simulator builds from sim.f
`timescale 1ns/100ps

module regReadTb;
  import regReadPkg::*;

  typedef logic [ISSUE_WIDTH-1:0] laneBits_t;

  localparam int FILL_CYCLES    = PHYS_REGS / ISSUE_WIDTH;
  localparam int RANDOM_CYCLES  = 816;
  localparam int SWEEP_CYCLES   = 4 * ISSUE_WIDTH * 2 * ISSUE_WIDTH;
  localparam int RECOVER_CYCLES = 400;
  localparam int SQUASH_CYCLES  = 400;
  localparam int READY_CYCLES   = 440;
  localparam int RUN_CYCLES     = FILL_CYCLES + RANDOM_CYCLES + SWEEP_CYCLES
                                + RECOVER_CYCLES + SQUASH_CYCLES + READY_CYCLES;
  localparam int CYCLE_LIMIT    = RUN_CYCLES + 800;  // Reset, drain and slack

  logic        clk = 1'b0;
  logic        reset_i;
  laneBits_t   laneValid_i;
  branchMask_t laneMask_i [ISSUE_WIDTH];
  physTag_t    laneSrc1_i [ISSUE_WIDTH];
  physTag_t    laneSrc2_i [ISSUE_WIDTH];
  physTag_t    laneDest_i [ISSUE_WIDTH];
  payload_t    lanePayload_i [ISSUE_WIDTH];
  laneBits_t   wbValid_i;
  physTag_t    wbTag_i [ISSUE_WIDTH];
  regData_t    wbData_i [ISSUE_WIDTH];
  logic        recover_i;
  logic        exception_i;
  logic        ctrlVerified_i;
  logic        ctrlMispredict_i;
  ckptId_t     ctrlCkptId_i;
  laneBits_t   unmapValid_i;
  physTag_t    unmapTag_i [ISSUE_WIDTH];
  laneBits_t   rsrValid_i;
  physTag_t    rsrTag_i [ISSUE_WIDTH];
  laneBits_t   laneValid_o;
  regData_t    laneSrc1Data_o [ISSUE_WIDTH];
  regData_t    laneSrc2Data_o [ISSUE_WIDTH];
  physTag_t    laneSrc1_o [ISSUE_WIDTH];
  physTag_t    laneSrc2_o [ISSUE_WIDTH];
  physTag_t    laneDest_o [ISSUE_WIDTH];
  payload_t    lanePayload_o [ISSUE_WIDTH];
  branchMask_t laneMask_o [ISSUE_WIDTH];
  readyVec_t   phyRegRdy_o;

  physTag_t    curTags [ISSUE_WIDTH];   // Writeback tags of this cycle
  physTag_t    prevTags [ISSUE_WIDTH];  // and of the cycle before
  bit          primed = 1'b0;
  int          cycleCount = 0;

  `include "regReadModel.svh"

  regReadStage dut (.*);

  always #2 clk = ~clk;

  task automatic checkValue(string name, logic [63:0] got, logic [63:0] want);
    if (got !== want) begin
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, want);
      $display("ERRORS FOUND");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic bit chance(int pct);
    return $urandom_range(99) < pct;
  endfunction

  // Mix of same-cycle hits, last-cycle tags and anything
  function automatic physTag_t pickTag(int hitPct);
    int roll;
    roll = $urandom_range(99);
    if (roll < hitPct) return curTags[$urandom_range(ISSUE_WIDTH-1)];
    if (roll < hitPct + 30) return prevTags[$urandom_range(ISSUE_WIDTH-1)];
    return physTag_t'($urandom);
  endfunction

  task automatic applyRandom(int recPct, int ctrlPct, int hitPct, int excPct);
    physTag_t base;
    physTag_t step;
    physTag_t unmapTags [ISSUE_WIDTH];
    @(posedge clk);
    prevTags = curTags;
    base = physTag_t'($urandom);
    step = physTag_t'(2 * $urandom_range(31) + 1);  // Odd step keeps port tags distinct
    for (int p = 0; p < ISSUE_WIDTH; p++) begin
      curTags[p] = base + physTag_t'(p) * step;
      unmapTags[p] = physTag_t'($urandom);
    end
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      wbTag_i[i]       <= curTags[i];
      wbData_i[i]      <= $urandom;
      unmapTag_i[i]    <= unmapTags[i];
      rsrTag_i[i]      <= chance(25) ? unmapTags[$urandom_range(ISSUE_WIDTH-1)]
                                     : physTag_t'($urandom);
      laneSrc1_i[i]    <= pickTag(hitPct);
      laneSrc2_i[i]    <= pickTag(hitPct);
      laneDest_i[i]    <= physTag_t'($urandom);
      lanePayload_i[i] <= payload_t'($urandom);
      laneMask_i[i]    <= branchMask_t'($urandom);
    end
    laneValid_i      <= laneBits_t'($urandom);
    wbValid_i        <= laneBits_t'($urandom);
    unmapValid_i     <= laneBits_t'($urandom);
    rsrValid_i       <= laneBits_t'($urandom);
    recover_i        <= chance(recPct);
    exception_i      <= chance(excPct);
    ctrlVerified_i   <= chance(ctrlPct);
    ctrlMispredict_i <= chance(60);
    ctrlCkptId_i     <= ckptId_t'($urandom);
  endtask

  task automatic applyIdle();
    @(posedge clk);
    laneValid_i    <= '0;
    wbValid_i      <= '0;
    unmapValid_i   <= '0;
    rsrValid_i     <= '0;
    recover_i      <= 1'b0;
    exception_i    <= 1'b0;
    ctrlVerified_i <= 1'b0;
  endtask

  // One lane and one writeback port per cycle over every pairing
  task automatic sweepForwarding(bit duringRecovery);
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      for (int s = 0; s < 2; s++) begin
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
          applyRandom(duringRecovery ? 100 : 0, 0, 0, 0);
          wbValid_i   <= laneBits_t'(1) << p;
          laneValid_i <= laneBits_t'(1) << l;
          if (s == 0) laneSrc1_i[l] <= curTags[p];
          else laneSrc2_i[l] <= curTags[p];
        end
      end
    end
  endtask

  // Outputs now belong to the inputs seen one negedge earlier
  always @(negedge clk) begin
    if (primed) begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        checkValue($sformatf("laneValid_o[%0d]", l), laneValid_o[l], expValid[l]);
        if (expLive[l]) begin
          checkValue($sformatf("laneSrc1Data_o[%0d]", l), laneSrc1Data_o[l], expSrc1Data[l]);
          checkValue($sformatf("laneSrc2Data_o[%0d]", l), laneSrc2Data_o[l], expSrc2Data[l]);
          checkValue($sformatf("laneSrc1_o[%0d]", l), laneSrc1_o[l], expSrc1[l]);
          checkValue($sformatf("laneSrc2_o[%0d]", l), laneSrc2_o[l], expSrc2[l]);
          checkValue($sformatf("laneDest_o[%0d]", l), laneDest_o[l], expDest[l]);
          checkValue($sformatf("lanePayload_o[%0d]", l), lanePayload_o[l], expPayload[l]);
          checkValue($sformatf("laneMask_o[%0d]", l), laneMask_o[l], expMask[l]);
        end
      end
      checkValue("phyRegRdy_o", phyRegRdy_o, expReady);
    end
    captureExpected();
    expReady = readyAfter(expReady);
    commitWrites();
    primed = 1'b1;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(32'h5c53));
    reset_i          = 1'b1;
    laneValid_i      = '0;
    wbValid_i        = '0;
    unmapValid_i     = '0;
    rsrValid_i       = '0;
    recover_i        = 1'b0;
    exception_i      = 1'b0;
    ctrlVerified_i   = 1'b0;
    ctrlMispredict_i = 1'b0;
    ctrlCkptId_i     = '0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      laneMask_i[i]    = '0;
      laneSrc1_i[i]    = '0;
      laneSrc2_i[i]    = '0;
      laneDest_i[i]    = '0;
      lanePayload_i[i] = '0;
      wbTag_i[i]       = '0;
      wbData_i[i]      = '0;
      unmapTag_i[i]    = '0;
      rsrTag_i[i]      = '0;
      curTags[i]       = '0;
    end
    repeat (2) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    checkValue("laneValid_o", laneValid_o, '0);
    checkValue("phyRegRdy_o", phyRegRdy_o, resetPattern());

    // Give every register a known value
    for (int c = 0; c < FILL_CYCLES; c++) begin
      applyRandom(0, 0, 0, 0);
      laneValid_i <= '0;
      wbValid_i   <= '1;
      for (int p = 0; p < ISSUE_WIDTH; p++) wbTag_i[p] <= physTag_t'(c * ISSUE_WIDTH + p);
    end

    repeat (RANDOM_CYCLES) applyRandom(0, 20, 30, 0);
    for (int r = 0; r < SWEEP_CYCLES / (2 * ISSUE_WIDTH * ISSUE_WIDTH); r++) begin
      sweepForwarding(r[0]);
    end
    repeat (RECOVER_CYCLES) applyRandom(50, 0, 40, 0);
    repeat (SQUASH_CYCLES) applyRandom(0, 70, 20, 0);
    repeat (READY_CYCLES - 2) applyRandom(20, 30, 20, 3);

    // Exception brings back the reset pattern
    applyRandom(0, 0, 0, 0);
    exception_i <= 1'b1;
    applyIdle();
    @(negedge clk);
    checkValue("phyRegRdy_o", phyRegRdy_o, resetPattern());

    repeat (3) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: sim.f
+incdir+sim
logic/regReadPkg.sv
logic/rfReadIf.sv
logic/physRegFile.sv
logic/laneOperandRead.sv
logic/readyTable.sv
logic/regReadStage.sv
sim/regReadTb.sv

// File: Bender.yml
package:
  name: reg_read_stage

sources:
  - files:
      - logic/regReadPkg.sv
      - logic/rfReadIf.sv
      - logic/physRegFile.sv
      - logic/laneOperandRead.sv
      - logic/readyTable.sv
      - logic/regReadStage.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/regReadTb.sv
